//--- rtl/watch_pkg.sv
// Constants shared by the watch RTL: mode and position codes, field and
// display widths, and the default divisors for a 50 MHz clock.
// Modules import it inside their body; port lists use scoped names.

package watch_pkg;

	// Modes, cycled in this order by the mode key
	localparam int MODE_W = 2;
	localparam logic [MODE_W-1:0] MODE_CLOCK = 2'd0;
	localparam logic [MODE_W-1:0] MODE_SETUP = 2'd1;
	localparam logic [MODE_W-1:0] MODE_ALARM = 2'd2;

	// Field selected for adjustment and blinking
	localparam int POS_W = 2;
	localparam logic [POS_W-1:0] POS_SEC  = 2'd0;
	localparam logic [POS_W-1:0] POS_MIN  = 2'd1;
	localparam logic [POS_W-1:0] POS_HOUR = 2'd2;

	localparam int FIELD_W = 6;
	localparam logic [FIELD_W-1:0] SEC_MAX  = 6'd59;
	localparam logic [FIELD_W-1:0] HOUR_MAX = 6'd23;

	localparam int DIGITS = 6;
	localparam int BCD_W  = 4;
	// Segments a..g, a in the MSB
	localparam int SEG_W  = 7;

	localparam int DEF_TICKS_PER_SEC = 50_000_000;
	localparam int DEF_SCAN_DIV      = 5_000;
	localparam int DEF_BLINK_DIV     = 12_500_000;

	// One step of a time field, back to zero past its last value
	function automatic logic [FIELD_W-1:0] field_inc(
		input logic [FIELD_W-1:0] value,
		input logic [FIELD_W-1:0] max_value
	);
		return (value >= max_value) ? '0 : value + FIELD_W'(1);
	endfunction

endpackage

//--- rtl/watch_ctrl_if.sv
// User control state of the watch, driven by the key controller
// through the ctrl modport and read by every other block through unit.

`timescale 1ns/100ps

interface watch_ctrl_if;
	import watch_pkg::*;

	logic [MODE_W-1:0] mode;
	logic [POS_W-1:0]  position;
	// One cycle per adjust key press
	logic              adj_pulse;
	logic              alarm_en;

	modport ctrl (output mode, output position, output adj_pulse, output alarm_en);
	modport unit (input mode, input position, input adj_pulse, input alarm_en);

endinterface

//--- rtl/key_ctrl.sv
// Key front end and control registers. Each key is synchronized,
// edge detected and registered as a one-cycle press, which then steps
// the mode, the position or the alarm enable, or becomes adj_pulse.

`timescale 1ns/100ps

module key_ctrl (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_key_mode,
	input  logic       i_key_pos,
	input  logic       i_key_adj,
	input  logic       i_key_alarm,
	watch_ctrl_if.ctrl ctrl
);
	import watch_pkg::*;

	localparam int KEYS    = 4;
	localparam int K_MODE  = 0;
	localparam int K_POS   = 1;
	localparam int K_ADJ   = 2;
	localparam int K_ALARM = 3;

	logic [KEYS-1:0] key_in;
	logic [KEYS-1:0] key_meta;
	logic [KEYS-1:0] key_sync;
	logic [KEYS-1:0] key_prev;
	logic [KEYS-1:0] press;

	assign key_in = {i_key_alarm, i_key_adj, i_key_pos, i_key_mode};

	// ----------------------------------------------------------------------
	// Synchronizer and rising edge, press is high one cycle per key-down
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			key_meta <= '0;
			key_sync <= '0;
			key_prev <= '0;
			press    <= '0;
		end else begin
			key_meta <= key_in;
			key_sync <= key_meta;
			key_prev <= key_sync;
			press    <= key_sync & ~key_prev;
		end
	end

	// ----------------------------------------------------------------------
	// Control state
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			ctrl.mode      <= MODE_CLOCK;
			ctrl.position  <= POS_SEC;
			ctrl.alarm_en  <= 1'b0;
			ctrl.adj_pulse <= 1'b0;
		end else begin
			if (press[K_MODE])
				ctrl.mode <= (ctrl.mode == MODE_ALARM) ? MODE_CLOCK : ctrl.mode + 1'b1;
			if (press[K_POS])
				ctrl.position <= (ctrl.position == POS_HOUR) ? POS_SEC : ctrl.position + 1'b1;
			if (press[K_ALARM])
				ctrl.alarm_en <= ~ctrl.alarm_en;
			ctrl.adj_pulse <= press[K_ADJ];
		end
	end

endmodule

//--- rtl/time_keeper.sv
// Time of day. A divider makes a one-cycle tick every TICKS_PER_SEC
// clocks while the watch runs; seconds, minutes and hours cascade on
// it. In setup mode the time stands still and adj_pulse steps the
// selected field.

`timescale 1ns/100ps

module time_keeper #(
	parameter int TICKS_PER_SEC = watch_pkg::DEF_TICKS_PER_SEC
) (
	input  logic                          clk,
	input  logic                          rst_n,
	watch_ctrl_if.unit                    ctl,
	output logic [watch_pkg::FIELD_W-1:0] o_sec,
	output logic [watch_pkg::FIELD_W-1:0] o_min,
	output logic [watch_pkg::FIELD_W-1:0] o_hour
);
	import watch_pkg::*;

	localparam int CNT_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICKS_PER_SEC - 1);

	logic [CNT_W-1:0] div_cnt;
	logic             tick;
	logic             running;

	assign running = (ctl.mode != MODE_SETUP);

	// Divider restarts when setup is left, so the first second is whole
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else if (!running) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else if (div_cnt == CNT_LAST) begin
			div_cnt <= '0;
			tick    <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick    <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_sec  <= '0;
			o_min  <= '0;
			o_hour <= '0;
		end else if (!running) begin
			// Setup: step one field, no carry
			if (ctl.adj_pulse) begin
				case (ctl.position)
					POS_SEC:  o_sec  <= field_inc(o_sec, SEC_MAX);
					POS_MIN:  o_min  <= field_inc(o_min, SEC_MAX);
					POS_HOUR: o_hour <= field_inc(o_hour, HOUR_MAX);
					default: ;
				endcase
			end
		end else if (tick) begin
			o_sec <= field_inc(o_sec, SEC_MAX);
			if (o_sec == SEC_MAX) begin
				o_min <= field_inc(o_min, SEC_MAX);
				if (o_min == SEC_MAX)
					o_hour <= field_inc(o_hour, HOUR_MAX);
			end
		end
	end

endmodule

//--- rtl/alarm_store.sv
// Alarm time registers. Only in alarm mode does adj_pulse step the
// field at the selected position, each wrapping on its own.

`timescale 1ns/100ps

module alarm_store (
	input  logic                          clk,
	input  logic                          rst_n,
	watch_ctrl_if.unit                    ctl,
	output logic [watch_pkg::FIELD_W-1:0] o_sec,
	output logic [watch_pkg::FIELD_W-1:0] o_min,
	output logic [watch_pkg::FIELD_W-1:0] o_hour
);
	import watch_pkg::*;

	logic adj_en;

	assign adj_en = ctl.adj_pulse && (ctl.mode == MODE_ALARM);

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_sec  <= '0;
			o_min  <= '0;
			o_hour <= '0;
		end else if (adj_en) begin
			case (ctl.position)
				POS_SEC:  o_sec  <= field_inc(o_sec, SEC_MAX);
				POS_MIN:  o_min  <= field_inc(o_min, SEC_MAX);
				POS_HOUR: o_hour <= field_inc(o_hour, HOUR_MAX);
				default: ;
			endcase
		end
	end

endmodule

//--- rtl/face_logic.sv
// Picks what the display shows and keeps the alarm flag.
// Alarm mode shows the alarm fields, the other modes the running time.
// Each field is split into tens and units for the digit bus.

`timescale 1ns/100ps

module face_logic (
	input  logic                                          clk,
	input  logic                                          rst_n,
	watch_ctrl_if.unit                                    ctl,
	input  logic [watch_pkg::FIELD_W-1:0]                 i_time_sec,
	input  logic [watch_pkg::FIELD_W-1:0]                 i_time_min,
	input  logic [watch_pkg::FIELD_W-1:0]                 i_time_hour,
	input  logic [watch_pkg::FIELD_W-1:0]                 i_alarm_sec,
	input  logic [watch_pkg::FIELD_W-1:0]                 i_alarm_min,
	input  logic [watch_pkg::FIELD_W-1:0]                 i_alarm_hour,
	output logic [watch_pkg::DIGITS*watch_pkg::BCD_W-1:0] o_digits,
	output logic                                          o_alarm
);
	import watch_pkg::*;

	logic [FIELD_W-1:0] show_sec;
	logic [FIELD_W-1:0] show_min;
	logic [FIELD_W-1:0] show_hour;
	logic               show_alarm;
	logic               match;

	function automatic logic [BCD_W-1:0] tens_of(input logic [FIELD_W-1:0] value);
		return BCD_W'(value / FIELD_W'(10));
	endfunction

	function automatic logic [BCD_W-1:0] units_of(input logic [FIELD_W-1:0] value);
		return BCD_W'(value % FIELD_W'(10));
	endfunction

	assign show_alarm = (ctl.mode == MODE_ALARM);
	assign show_sec   = show_alarm ? i_alarm_sec : i_time_sec;
	assign show_min   = show_alarm ? i_alarm_min : i_time_min;
	assign show_hour  = show_alarm ? i_alarm_hour : i_time_hour;

	// Digit 0 sits in the low nibble
	assign o_digits = {tens_of(show_hour), units_of(show_hour),
		tens_of(show_min), units_of(show_min),
		tens_of(show_sec), units_of(show_sec)};

	assign match = (i_time_sec == i_alarm_sec) && (i_time_min == i_alarm_min) &&
		(i_time_hour == i_alarm_hour);

	// Latches on a match, held until the alarm is disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0)
			o_alarm <= 1'b0;
		else
			o_alarm <= ctl.alarm_en & (o_alarm | match);
	end

endmodule

//--- rtl/seg_scan.sv
// Display scanner. Steps one active-low enable across the six digits,
// decodes the current digit to segments and shows the mode code on the
// decimal points of digits 0 and 1. Outside clock mode the selected
// pair blinks. All outputs are registered.

`timescale 1ns/100ps

module seg_scan #(
	parameter int SCAN_DIV  = watch_pkg::DEF_SCAN_DIV,
	parameter int BLINK_DIV = watch_pkg::DEF_BLINK_DIV
) (
	input  logic                                          clk,
	input  logic                                          rst_n,
	watch_ctrl_if.unit                                    ctl,
	input  logic [watch_pkg::DIGITS*watch_pkg::BCD_W-1:0] i_digits,
	output logic [watch_pkg::DIGITS-1:0]                  o_seg_enb,
	output logic [watch_pkg::SEG_W-1:0]                   o_seg,
	output logic                                          o_seg_dp
);
	import watch_pkg::*;

	localparam int SCAN_W  = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam int BLINK_W = (BLINK_DIV > 1) ? $clog2(BLINK_DIV) : 1;
	localparam int IDX_W   = $clog2(DIGITS);
	localparam logic [SCAN_W-1:0]  SCAN_LAST  = SCAN_W'(SCAN_DIV - 1);
	localparam logic [BLINK_W-1:0] BLINK_LAST = BLINK_W'(BLINK_DIV - 1);
	localparam logic [IDX_W-1:0]   IDX_LAST   = IDX_W'(DIGITS - 1);

	logic [SCAN_W-1:0]  scan_cnt;
	logic [BLINK_W-1:0] blink_cnt;
	logic [IDX_W-1:0]   idx;
	logic               blink;
	logic [BCD_W-1:0]   cur_digit;
	logic               pair_off;
	logic [DIGITS-1:0]  enb_next;
	logic [SEG_W-1:0]   seg_next;
	logic               dp_next;

	// ----------------------------------------------------------------------
	// Scan index and blink phase
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			scan_cnt  <= '0;
			idx       <= '0;
			blink_cnt <= '0;
			blink     <= 1'b0;
		end else begin
			if (scan_cnt == SCAN_LAST) begin
				scan_cnt <= '0;
				idx      <= (idx == IDX_LAST) ? '0 : idx + 1'b1;
			end else begin
				scan_cnt <= scan_cnt + 1'b1;
			end
			if (blink_cnt == BLINK_LAST) begin
				blink_cnt <= '0;
				blink     <= ~blink;
			end else begin
				blink_cnt <= blink_cnt + 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Next outputs for the current slot
	// ----------------------------------------------------------------------
	assign cur_digit = i_digits[int'(idx)*BCD_W +: BCD_W];

	// Digits 2k and 2k+1 form the pair of position k
	assign pair_off = blink && (ctl.mode != MODE_CLOCK) && (POS_W'(idx >> 1) == ctl.position);
	assign enb_next = pair_off ? '1 : ~(DIGITS'(1) << idx);

	always_comb begin
		case (cur_digit)
			4'd0:    seg_next = 7'b111_1110;
			4'd1:    seg_next = 7'b011_0000;
			4'd2:    seg_next = 7'b110_1101;
			4'd3:    seg_next = 7'b111_1001;
			4'd4:    seg_next = 7'b011_0011;
			4'd5:    seg_next = 7'b101_1011;
			4'd6:    seg_next = 7'b101_1111;
			4'd7:    seg_next = 7'b111_0000;
			4'd8:    seg_next = 7'b111_1111;
			4'd9:    seg_next = 7'b111_0011;
			default: seg_next = 7'b000_0000;
		endcase
	end

	always_comb begin
		case (idx)
			3'd0:    dp_next = ctl.mode[0];
			3'd1:    dp_next = ctl.mode[1];
			default: dp_next = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_seg_enb <= ~DIGITS'(1);
			o_seg     <= '0;
			o_seg_dp  <= 1'b0;
		end else begin
			o_seg_enb <= enb_next;
			o_seg     <= seg_next;
			o_seg_dp  <= dp_next;
		end
	end

endmodule

//--- rtl/watch_top.sv
// Top level of the hour:minute:second watch with one daily alarm.
// Four level keys in, a scanned six-digit seven-segment display and
// an alarm level out. The divisors are parameters so a simulation
// can run with short seconds.

`timescale 1ns/100ps

module watch_top #(
	parameter int TICKS_PER_SEC = watch_pkg::DEF_TICKS_PER_SEC,
	parameter int SCAN_DIV      = watch_pkg::DEF_SCAN_DIV,
	parameter int BLINK_DIV     = watch_pkg::DEF_BLINK_DIV
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_key_mode,
	input  logic                          i_key_pos,
	input  logic                          i_key_adj,
	input  logic                          i_key_alarm,
	output logic [watch_pkg::DIGITS-1:0]  o_seg_enb,
	output logic [watch_pkg::SEG_W-1:0]   o_seg,
	output logic                          o_seg_dp,
	output logic                          o_alarm
);
	import watch_pkg::*;

	logic [FIELD_W-1:0]      time_sec;
	logic [FIELD_W-1:0]      time_min;
	logic [FIELD_W-1:0]      time_hour;
	logic [FIELD_W-1:0]      alarm_sec;
	logic [FIELD_W-1:0]      alarm_min;
	logic [FIELD_W-1:0]      alarm_hour;
	logic [DIGITS*BCD_W-1:0] digits;

	watch_ctrl_if ctrl_bus ();

	key_ctrl key_ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_key_mode  (i_key_mode),
		.i_key_pos   (i_key_pos),
		.i_key_adj   (i_key_adj),
		.i_key_alarm (i_key_alarm),
		.ctrl        (ctrl_bus.ctrl)
	);

	time_keeper #(.TICKS_PER_SEC(TICKS_PER_SEC)) time_keeper_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.ctl    (ctrl_bus.unit),
		.o_sec  (time_sec),
		.o_min  (time_min),
		.o_hour (time_hour)
	);

	alarm_store alarm_store_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.ctl    (ctrl_bus.unit),
		.o_sec  (alarm_sec),
		.o_min  (alarm_min),
		.o_hour (alarm_hour)
	);

	face_logic face_logic_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.ctl          (ctrl_bus.unit),
		.i_time_sec   (time_sec),
		.i_time_min   (time_min),
		.i_time_hour  (time_hour),
		.i_alarm_sec  (alarm_sec),
		.i_alarm_min  (alarm_min),
		.i_alarm_hour (alarm_hour),
		.o_digits     (digits),
		.o_alarm      (o_alarm)
	);

	seg_scan #(.SCAN_DIV(SCAN_DIV), .BLINK_DIV(BLINK_DIV)) seg_scan_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctl       (ctrl_bus.unit),
		.i_digits  (digits),
		.o_seg_enb (o_seg_enb),
		.o_seg     (o_seg),
		.o_seg_dp  (o_seg_dp)
	);

endmodule

//--- bench/tb_clk_gen.sv
// Free-running testbench clock, 10 ns period by default

`timescale 1ns/100ps

module tb_clk_gen #(
	parameter int PERIOD_NS = 10
) (
	output logic o_clk
);
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end
endmodule

//--- bench/watch_asserts.sv
// Concurrent checks on the watch top level, bound into watch_top.
// Covers the digit enables and the alarm output around reset and disable.

`timescale 1ns/100ps

module watch_asserts (
	input logic                         clk,
	input logic                         rst_n,
	input logic [watch_pkg::DIGITS-1:0] i_seg_enb,
	input logic                         i_alarm,
	input logic                         i_alarm_en
);
	// Never two digits driven at once
	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~i_seg_enb) <= 1)
		else $error("more than one digit enable is low");

	a_alarm_in_reset: assert property (@(posedge clk) !rst_n |-> !i_alarm)
		else $error("o_alarm high during reset");

	// Flag clears the cycle after the enable drops
	a_alarm_clears: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(i_alarm_en) |=> !i_alarm)
		else $error("o_alarm still high after alarm disable");
endmodule

bind watch_top watch_asserts watch_asserts_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_seg_enb  (o_seg_enb),
	.i_alarm    (o_alarm),
	.i_alarm_en (ctrl_bus.alarm_en)
);

//--- bench/watch_tb.sv
// Directed testbench for the watch. Reads the scanned display back into
// hours, minutes and seconds and walks through reset, time setup,
// running, alarm setup, alarm firing and blinking.

`timescale 1ns/100ps

module watch_tb;
	import watch_pkg::*;

	localparam int TICKS     = 20;
	localparam int SCAN      = 2;
	localparam int BLINK     = 40;
	localparam int KEY_HOLD  = 6;
	localparam int READ_WAIT = 4 * BLINK;

	localparam int KEY_MODE  = 0;
	localparam int KEY_POS   = 1;
	localparam int KEY_ADJ   = 2;
	localparam int KEY_ALARM = 3;

	logic              clk;
	logic              rst_n;
	logic              key_mode;
	logic              key_pos;
	logic              key_adj;
	logic              key_alarm;
	logic [DIGITS-1:0] seg_enb;
	logic [SEG_W-1:0]  seg;
	logic              seg_dp;
	logic              alarm;

	int errors;
	int tests_run;
	int tests_failed;

	tb_clk_gen clk_gen_i (.o_clk(clk));

	watch_top #(.TICKS_PER_SEC(TICKS), .SCAN_DIV(SCAN), .BLINK_DIV(BLINK)) watch_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_key_mode  (key_mode),
		.i_key_pos   (key_pos),
		.i_key_adj   (key_adj),
		.i_key_alarm (key_alarm),
		.o_seg_enb   (seg_enb),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_alarm     (alarm)
	);

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	task automatic check(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("[FAIL] %0t ns %s: expected %0d, got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("Error at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("ok    %s", name);
		end else begin
			tests_failed++;
			$display("bad   %s, %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic set_key(input int which, input logic level);
		case (which)
			KEY_MODE:  key_mode <= level;
			KEY_POS:   key_pos <= level;
			KEY_ADJ:   key_adj <= level;
			default:   key_alarm <= level;
		endcase
	endtask

	// One press held 6 cycles, then released for 6
	task automatic press(input int which);
		@(posedge clk);
		set_key(which, 1'b1);
		repeat (KEY_HOLD) @(posedge clk);
		set_key(which, 1'b0);
		repeat (KEY_HOLD - 1) @(posedge clk);
	endtask

	// Segments a to g with a in the MSB
	function automatic logic [SEG_W-1:0] seg_pattern(input int digit);
		case (digit)
			0:       return 7'b1111110;
			1:       return 7'b0110000;
			2:       return 7'b1101101;
			3:       return 7'b1111001;
			4:       return 7'b0110011;
			5:       return 7'b1011011;
			6:       return 7'b1011111;
			7:       return 7'b1110000;
			8:       return 7'b1111111;
			9:       return 7'b1110011;
			default: return 7'b0000000;
		endcase
	endfunction

	function automatic int seg_to_digit(input logic [SEG_W-1:0] pattern);
		for (int d = 0; d <= 9; d++) begin
			if (seg_pattern(d) == pattern)
				return d;
		end
		return -1;
	endfunction

	// Waits for each digit's slot; blanked slots simply keep it waiting
	task automatic read_display(output int hour, output int min, output int sec);
		int value [DIGITS];
		int waited;
		bit seen;
		for (int d = 0; d < DIGITS; d++) begin
			seen = 1'b0;
			waited = 0;
			while (!seen && waited < READ_WAIT) begin
				@(negedge clk);
				waited++;
				seen = (seg_enb == ~(DIGITS'(1) << d));
			end
			if (!seen) begin
				report_problem($sformatf("digit %0d was never enabled", d));
				value[d] = -1;
			end else begin
				value[d] = seg_to_digit(seg);
			end
		end
		sec = value[1] * 10 + value[0];
		min = value[3] * 10 + value[2];
		hour = value[5] * 10 + value[4];
	endtask

	task automatic wait_alarm(input logic level, input int limit, output bit reached);
		int waited;
		waited = 0;
		reached = 1'b0;
		while (!reached && waited < limit) begin
			@(negedge clk);
			waited++;
			reached = (alarm == level);
		end
	endtask

	// ----------------------------------------------------------------------
	// Tests
	// ----------------------------------------------------------------------
	task automatic test_reset();
		int h;
		int m;
		int s;
		int start_err;
		logic [DIGITS-1:0] lit;
		start_err = errors;
		read_display(h, m, s);
		check("display hours", 0, h);
		check("display minutes", 0, m);
		check("display seconds", 0, s);
		check("o_alarm", 0, int'(alarm));
		lit = '0;
		repeat (2 * DIGITS * SCAN) begin
			@(negedge clk);
			check("o_seg_enb one low", 1, int'($onehot(~seg_enb)));
			lit = lit | ~seg_enb;
		end
		check("o_seg_enb all digits scanned", 1, int'(&lit));
		finish_test("reset state and scan", start_err);
	endtask

	task automatic test_set_time();
		int h;
		int m;
		int s;
		int nh;
		int nm;
		int ns;
		int start_err;
		start_err = errors;
		press(KEY_MODE);
		read_display(h, m, s);
		// Up to 59, then one more wraps with no carry
		repeat ((59 - s + 60) % 60) press(KEY_ADJ);
		press(KEY_ADJ);
		read_display(nh, nm, ns);
		check("seconds after wrap", 0, ns);
		check("minutes after seconds wrap", 0, nm);
		check("hours after seconds wrap", 0, nh);
		repeat (58) press(KEY_ADJ);
		press(KEY_POS);
		repeat ((59 - m + 60) % 60) press(KEY_ADJ);
		press(KEY_POS);
		repeat ((23 - h + 24) % 24) press(KEY_ADJ);
		read_display(nh, nm, ns);
		check("set hours", 23, nh);
		check("set minutes", 59, nm);
		check("set seconds", 58, ns);
		cycles(3 * TICKS);
		read_display(nh, nm, ns);
		check("frozen hours", 23, nh);
		check("frozen minutes", 59, nm);
		check("frozen seconds", 58, ns);
		finish_test("time setup", start_err);
	endtask

	task automatic test_run();
		int h;
		int m;
		int s;
		int start_err;
		start_err = errors;
		// Setup to alarm to clock, and the time runs from the first press on
		press(KEY_MODE);
		press(KEY_MODE);
		cycles(3 * TICKS);
		read_display(h, m, s);
		check("hours after midnight", 0, h);
		check("minutes after midnight", 0, m);
		check("seconds 1 to 3 after midnight", 1, int'(s >= 1 && s <= 3));
		finish_test("running time wraps at midnight", start_err);
	endtask

	task automatic test_alarm_set();
		int h;
		int m;
		int s;
		int target;
		int start_err;
		start_err = errors;
		read_display(h, m, s);
		target = (s + 30) % 60;
		press(KEY_MODE);
		press(KEY_MODE);
		// Position was left on hours
		press(KEY_POS);
		repeat (target) press(KEY_ADJ);
		read_display(h, m, s);
		check("alarm hours shown", 0, h);
		check("alarm minutes shown", 0, m);
		check("alarm seconds shown", target, s);
		finish_test("alarm setup", start_err);
	endtask

	task automatic test_alarm_fire();
		bit reached;
		int start_err;
		start_err = errors;
		press(KEY_ALARM);
		// The running time is still some seconds short of the alarm
		check("o_alarm before the alarm time", 0, int'(alarm));
		wait_alarm(1'b1, 40 * TICKS, reached);
		if (!reached) begin
			report_problem("o_alarm never rose after the alarm time");
		end else begin
			repeat (2 * TICKS) begin
				@(negedge clk);
				check("o_alarm held", 1, int'(alarm));
			end
		end
		press(KEY_ALARM);
		wait_alarm(1'b0, 4 * KEY_HOLD, reached);
		if (!reached)
			report_problem("o_alarm stayed high after the alarm was disabled");
		finish_test("alarm fires and clears", start_err);
	endtask

	task automatic test_blink();
		int gap [DIGITS];
		bit seen_off;
		bit seen_on;
		int start_err;
		start_err = errors;
		press(KEY_MODE);
		press(KEY_MODE);
		seen_off = 1'b0;
		seen_on = 1'b0;
		for (int k = 0; k < DIGITS; k++)
			gap[k] = 0;
		// Two blink periods, so the pair is seen both dark and lit
		repeat (4 * BLINK) begin
			@(negedge clk);
			for (int k = 0; k < DIGITS; k++) begin
				if (seg_enb[k] == 1'b0)
					gap[k] = 0;
				else
					gap[k]++;
			end
			// Dark for longer than one scan round means blanked
			if (gap[0] > DIGITS * SCAN)
				seen_off = 1'b1;
			for (int k = 2; k < DIGITS; k++) begin
				if (gap[k] > DIGITS * SCAN) begin
					report_problem($sformatf("digit %0d blanked with seconds selected", k));
					gap[k] = 0;
				end
			end
			if (seg_enb[0] == 1'b0) begin
				seen_on = 1'b1;
				check("o_seg_dp digit 0", int'(MODE_SETUP[0]), int'(seg_dp));
			end
			if (seg_enb[1] == 1'b0)
				check("o_seg_dp digit 1", int'(MODE_SETUP[1]), int'(seg_dp));
		end
		if (!seen_off)
			report_problem("seconds pair never blanked in setup mode");
		if (!seen_on)
			report_problem("seconds pair never lit in setup mode");
		finish_test("setup blink and decimal points", start_err);
	endtask

	// ----------------------------------------------------------------------
	// Sequence
	// ----------------------------------------------------------------------
	initial begin
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst_n = 1'b0;
		key_mode = 1'b0;
		key_pos = 1'b0;
		key_adj = 1'b0;
		key_alarm = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		// Let the first decoded digit reach the outputs
		cycles(2);
		test_reset();
		test_set_time();
		test_run();
		test_alarm_set();
		test_alarm_fire();
		test_blink();
		$display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end
endmodule

//--- verilog.f
rtl/watch_pkg.sv
rtl/watch_ctrl_if.sv
rtl/key_ctrl.sv
rtl/time_keeper.sv
rtl/alarm_store.sv
rtl/face_logic.sv
rtl/seg_scan.sv
rtl/watch_top.sv
bench/tb_clk_gen.sv
bench/watch_asserts.sv
bench/watch_tb.sv

//--- run.sh
#!/bin/sh
# Builds the watch testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module watch_tb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vwatch_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
